// File: Bender.yml
package:
  name: rv_core

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/rv_core_pkg.sv
      - hdl/rv_reg_file.sv
      - hdl/rv_decode.sv
      - hdl/rv_execute.sv
      - hdl/rv_core.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - bench/rv_core_tb.sv

// File: bench/rv_core_tb.sv
`default_nettype none

`include "rv_core_cfg.svh"

module rv_core_tb import rv_core_pkg::*;;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int ALU_N     = 40;
    localparam int WORD_N    = 24;
    localparam int CHAIN_N   = 16;
    localparam int X0_N      = 6;
    localparam int ILL_N     = 40;
    localparam int GAP       = 3;
    localparam int NUM_TESTS = 6;
    // reset, idle and issue slots of all tests, gaps included
    localparam int SLOT_CYCLES = 5 + 8 + 62 + ALU_N * (GAP + 1) + WORD_N * (GAP + 1)
                                 + 3 * CHAIN_N + 4 * X0_N + ILL_N + 31;
    localparam int CYCLE_LIMIT = SLOT_CYCLES + 3 * NUM_TESTS + 50;

    logic                      clk;
    logic                      rst_n;
    logic                      in_valid;
    logic [31:0]               instr;
    logic                      wb_valid;
    logic [`RV_REG_ADDR_W-1:0] wb_rd;
    logic [`RV_XLEN-1:0]       wb_data;
    logic                      illegal;

    logic [31:0]         lfsr = 32'hc1f7bc63;
    logic [`RV_XLEN-1:0] mregs [0:`RV_REG_COUNT-1];  // reference register file
    logic                exp_ill [$];
    logic [4:0]          exp_rd [$];
    logic [63:0]         exp_data [$];
    int                  exp_cyc [$];                // cycle count when the strobe is due
    int                  cycles = 0;
    int                  test_errs = 0;
    int                  pass_cnt = 0;
    int                  fail_cnt = 0;
    string               cur_test = "none";

    rv_core u_dut (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .instr    (instr),
        .wb_valid (wb_valid),
        .wb_rd    (wb_rd),
        .wb_data  (wb_data),
        .illegal  (illegal)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: run went past %0d cycles in test %s", CYCLE_LIMIT, cur_test);
            $display("Test failures found");
            $finish;
        end
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = lfsr_step(lfsr);
            v = {v[62:0], lfsr[31]};  // one step per bit
        end
        return v;
    endfunction

    function automatic logic [63:0] sext32(input logic [31:0] x);
        return {{32{x[31]}}, x};
    endfunction

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [6:0] opc);
        return {f7, rs2, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    // base integer ISA semantics for OP and OP-IMM
    function automatic logic [63:0] alu_model(input logic [2:0] f3, input logic alt,
                                              input logic [63:0] a, input logic [63:0] b);
        logic [63:0] r;
        case (f3)
            3'd0: r = alt ? a - b : a + b;
            3'd1: r = a << b[5:0];
            3'd2: r = {63'b0, $signed(a) < $signed(b)};
            3'd3: r = {63'b0, a < b};
            3'd4: r = a ^ b;
            3'd5: begin
                if (alt) begin
                    r = $signed(a) >>> b[5:0];
                end else begin
                    r = a >> b[5:0];
                end
            end
            3'd6: r = a | b;
            default: r = a & b;
        endcase
        return r;
    endfunction

    task automatic model_exec(input logic [31:0] ins, output logic [63:0] res, output logic bad);
        logic [6:0]  opc;
        logic [2:0]  f3;
        logic [63:0] a;
        logic [63:0] b;
        opc = ins[6:0];
        f3  = ins[14:12];
        a   = mregs[ins[19:15]];
        b   = (opc == OPC_OP || opc == OPC_OP_32) ? mregs[ins[24:20]] : {{52{ins[31]}}, ins[31:20]};
        res = '0;
        bad = 1'b0;
        case (opc)
            OPC_OP:        res = alu_model(f3, ins[30], a, b);
            OPC_OP_IMM:    res = alu_model(f3, ins[30] && (f3 == 3'd5), a, b);  // no subi
            OPC_OP_32: begin
                if (f3 != 3'd0) begin
                    bad = 1'b1;
                end else if (ins[30]) begin
                    res = sext32(a[31:0] - b[31:0]);
                end else begin
                    res = sext32(a[31:0] + b[31:0]);
                end
            end
            OPC_OP_IMM_32: begin
                bad = (f3 != 3'd0);
                res = bad ? '0 : sext32(a[31:0] + b[31:0]);
            end
            OPC_LUI:       res = sext32({ins[31:12], 12'b0});
            default:       bad = 1'b1;
        endcase
        if (!bad && ins[11:7] != 5'd0) begin
            mregs[ins[11:7]] = res;
        end
    endtask

    function automatic logic [31:0] random_alu_instr();
        logic [2:0]  f3;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic        alt;
        logic [11:0] imm;
        f3  = 3'(rand_bits(3));
        rd  = 5'(rand_bits(5));
        rs1 = 5'(rand_bits(5));
        rs2 = 5'(rand_bits(5));
        alt = 1'(rand_bits(1));
        imm = 12'(rand_bits(12));
        if (rand_bits(1) == 64'd1) begin
            alt = alt && (f3 == 3'd0 || f3 == 3'd5);
            return r_type({1'b0, alt, 5'b0}, rs2, rs1, f3, rd, OPC_OP);
        end
        if (f3 == 3'd1) begin
            imm = {6'b0, imm[5:0]};
        end else if (f3 == 3'd5) begin
            imm = {1'b0, alt, 4'b0, imm[5:0]};  // srli or srai
        end
        return i_type(imm, rs1, f3, rd, OPC_OP_IMM);
    endfunction

    function automatic logic [31:0] random_illegal_instr();
        logic [31:0] ins;
        logic [1:0]  kind;
        ins  = 32'(rand_bits(32));
        kind = 2'(rand_bits(2));
        if (kind == 2'd2 || kind == 2'd3) begin
            ins[6:0] = (kind == 2'd2) ? OPC_OP_32 : OPC_OP_IMM_32;
            if (ins[14:12] == 3'd0) begin
                ins[14:12] = 3'd7;  // any funct3 but the add form
            end
        end else begin
            while (ins[6:0] inside {OPC_OP, OPC_OP_IMM, OPC_OP_32, OPC_OP_IMM_32, OPC_LUI}) begin
                ins[6:0] = 7'(rand_bits(7));
            end
        end
        return ins;
    endfunction

    task automatic send(input logic [31:0] ins);
        logic [63:0] res;
        logic        bad;
        model_exec(ins, res, bad);
        in_valid = 1'b1;
        instr    = ins;
        exp_ill.push_back(bad);
        exp_rd.push_back(ins[11:7]);
        exp_data.push_back(res);
        exp_cyc.push_back(cycles + 2);
        @(posedge clk);
        #2;
        in_valid = 1'b0;
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            #2;
        end
    endtask

    task automatic start_test(input string name);
        cur_test  = name;
        test_errs = 0;
    endtask

    task automatic end_test();
        while (exp_rd.size() != 0) begin
            @(negedge clk);
        end
        if (test_errs == 0) begin
            pass_cnt++;
            $display("test %s: pass", cur_test);
        end else begin
            fail_cnt++;
            $display("test %s: FAIL with %0d errors", cur_test, test_errs);
        end
    endtask

    task automatic drop_head();
        void'(exp_ill.pop_front());
        void'(exp_rd.pop_front());
        void'(exp_data.pop_front());
        void'(exp_cyc.pop_front());
    endtask

    // outputs are compared mid-cycle
    always @(negedge clk) begin
        if (!rst_n) begin
            if (wb_valid || illegal) begin
                $display("%s: output strobe is high while reset is asserted", cur_test);
                test_errs++;
            end
        end else if (wb_valid || illegal) begin
            if (exp_rd.size() == 0 || exp_cyc[0] != cycles) begin
                $display("%s: strobe at cycle %0d with no instruction due", cur_test, cycles);
                test_errs++;
            end else begin
                if ({wb_valid, illegal} != {!exp_ill[0], exp_ill[0]}) begin
                    $display("Mismatch in %s: wb_valid,illegal expected %b, actual %b",
                             cur_test, {!exp_ill[0], exp_ill[0]}, {wb_valid, illegal});
                    test_errs++;
                end else if (!exp_ill[0] && wb_rd != exp_rd[0]) begin
                    $display("Mismatch in %s: wb_rd expected %0d, actual %0d",
                             cur_test, exp_rd[0], wb_rd);
                    test_errs++;
                end else if (!exp_ill[0] && wb_data != exp_data[0]) begin
                    $display("Mismatch in %s: wb_data expected %h, actual %h",
                             cur_test, exp_data[0], wb_data);
                    test_errs++;
                end
                drop_head();
            end
        end else if (exp_rd.size() != 0 && exp_cyc[0] == cycles) begin
            $display("%s: no strobe for the instruction due at cycle %0d", cur_test, cycles);
            test_errs++;
            drop_head();
        end
    end

    initial begin
        logic [31:0] ins;
        logic [4:0]  rd;
        logic [1:0]  kind;
        clk      = 1'b0;
        rst_n    = 1'b0;
        in_valid = 1'b0;
        instr    = '0;
        for (int r = 0; r < `RV_REG_COUNT; r++) begin
            mregs[r] = '0;
        end

        start_test("reset");
        repeat (5) @(posedge clk);
        #2;
        rst_n = 1'b1;
        idle(4);  // nothing may come out yet
        repeat (4) begin
            send(r_type(7'b0, 5'(rand_bits(5)), 5'(rand_bits(5)), 3'(rand_bits(3)),
                        5'(rand_bits(5)), OPC_OP));
        end
        end_test();

        start_test("alu_ops");
        for (int r = 1; r < `RV_REG_COUNT; r++) begin
            send({20'(rand_bits(20)), 5'(r), OPC_LUI});
            send(i_type(12'(rand_bits(12)), 5'(r), 3'd0, 5'(r), OPC_OP_IMM));
        end
        repeat (ALU_N) begin
            send(random_alu_instr());
            idle(GAP);
        end
        end_test();

        start_test("word_ops_lui");
        repeat (WORD_N) begin
            kind = 2'(rand_bits(2));
            ins  = 32'(rand_bits(32));
            case (kind)
                2'd0:    ins = r_type(7'b0000000, ins[24:20], ins[19:15], 3'd0, ins[11:7], OPC_OP_32);
                2'd1:    ins = r_type(7'b0100000, ins[24:20], ins[19:15], 3'd0, ins[11:7], OPC_OP_32);
                2'd2:    ins = i_type(ins[31:20], ins[19:15], 3'd0, ins[11:7], OPC_OP_IMM_32);
                default: ins[6:0] = OPC_LUI;
            endcase
            send(ins);
            idle(GAP);
        end
        end_test();

        start_test("dependent_chains");
        for (int d = 1; d <= 3; d++) begin
            for (int i = 0; i < CHAIN_N; i++) begin
                ins = random_alu_instr();
                ins[11:7] = 5'(8 * (d - 1) + 1 + (i % 4));  // rd cycles over four registers
                if (i >= d) begin
                    ins[19:15] = 5'(8 * (d - 1) + 1 + ((i - d) % 4));
                    if (ins[6:0] == OPC_OP) begin
                        ins[24:20] = ins[19:15];  // rs2 follows the chain too
                    end
                end
                send(ins);
            end
        end
        end_test();

        start_test("x0_writes");
        repeat (X0_N) begin
            ins = random_alu_instr();
            ins[11:7] = 5'd0;
            send(ins);
            send(r_type(7'b0, 5'd0, 5'd0, 3'd6, 5'd9, OPC_OP));                  // or x9, x0, x0
            send(i_type(12'(rand_bits(12)), 5'd0, 3'd4, 5'd10, OPC_OP_IMM));     // xori x10, x0
            send(r_type(7'b0, 5'd0, 5'd0, 3'd0, 5'd11, OPC_OP));                 // add x11, x0, x0
        end
        end_test();

        start_test("illegal_opcodes");
        repeat (ILL_N) begin
            if (rand_bits(2) == 64'd0) begin
                send(random_illegal_instr());
            end else begin
                send(random_alu_instr());
            end
        end
        for (int r = 1; r < `RV_REG_COUNT; r++) begin
            rd = 5'(r);
            send(i_type(12'd0, rd, 3'd0, rd, OPC_OP_IMM));  // read back every register
        end
        end_test();

        $display("tests passed: %0d, tests failed: %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: flist.f
+incdir+hdl
hdl/rv_core_pkg.sv
hdl/rv_reg_file.sv
hdl/rv_decode.sv
hdl/rv_execute.sv
hdl/rv_core.sv
bench/rv_core_tb.sv

// File: hdl/rv_core.sv
`default_nettype none

`include "rv_core_cfg.svh"

module rv_core import rv_core_pkg::*; (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      in_valid,
    input  logic [31:0]               instr,
    output logic                      wb_valid,
    output logic [`RV_REG_ADDR_W-1:0] wb_rd,
    output logic [`RV_XLEN-1:0]       wb_data,
    output logic                      illegal
);

    logic [`RV_REG_ADDR_W-1:0] rs1_addr;
    logic [`RV_REG_ADDR_W-1:0] rs2_addr;
    logic [`RV_XLEN-1:0]       rs1_data;
    logic [`RV_XLEN-1:0]       rs2_data;
    logic                      id_valid;
    logic                      id_illegal;
    rv_alu_op_e                id_op;
    logic                      id_word;
    logic [`RV_XLEN-1:0]       id_a;
    logic [`RV_XLEN-1:0]       id_b;
    logic [`RV_REG_ADDR_W-1:0] id_rd;
    logic                      ex_valid;
    logic [`RV_REG_ADDR_W-1:0] ex_rd;
    logic [`RV_XLEN-1:0]       ex_result;

    rv_decode u_decode (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .instr      (instr),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .ex_valid   (ex_valid),
        .ex_rd      (ex_rd),
        .ex_result  (ex_result),
        .rs1_addr   (rs1_addr),
        .rs2_addr   (rs2_addr),
        .id_valid   (id_valid),
        .id_illegal (id_illegal),
        .id_op      (id_op),
        .id_word    (id_word),
        .id_a       (id_a),
        .id_b       (id_b),
        .id_rd      (id_rd)
    );

    rv_reg_file u_reg_file (
        .clk      (clk),
        .rst_n    (rst_n),
        .wb_valid (wb_valid),
        .wb_rd    (wb_rd),
        .wb_data  (wb_data),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    rv_execute u_execute (
        .clk        (clk),
        .rst_n      (rst_n),
        .id_valid   (id_valid),
        .id_illegal (id_illegal),
        .id_op      (id_op),
        .id_word    (id_word),
        .id_a       (id_a),
        .id_b       (id_b),
        .id_rd      (id_rd),
        .ex_valid   (ex_valid),
        .ex_rd      (ex_rd),
        .ex_result  (ex_result),
        .wb_valid   (wb_valid),
        .wb_rd      (wb_rd),
        .wb_data    (wb_data),
        .illegal    (illegal)
    );

endmodule

`default_nettype wire

// File: hdl/rv_core_cfg.svh
`ifndef RV_CORE_CFG_SVH
`define RV_CORE_CFG_SVH

// datapath width, RV64
`define RV_XLEN 64

// register file geometry
`define RV_REG_ADDR_W 5
`define RV_REG_COUNT 32

`endif

// File: hdl/rv_core_pkg.sv
`default_nettype none

`include "rv_core_cfg.svh"

package rv_core_pkg;

    // register-register layout, also used for the register fields of other formats
    typedef struct packed {
        logic [6:0]                funct7;
        logic [`RV_REG_ADDR_W-1:0] rs2;
        logic [`RV_REG_ADDR_W-1:0] rs1;
        logic [2:0]                funct3;
        logic [`RV_REG_ADDR_W-1:0] rd;
        logic [6:0]                opcode;
    } rv_r_fmt_t;

    typedef struct packed {
        logic [11:0]               imm12;
        logic [`RV_REG_ADDR_W-1:0] rs1;
        logic [2:0]                funct3;
        logic [`RV_REG_ADDR_W-1:0] rd;
        logic [6:0]                opcode;
    } rv_i_fmt_t;

    typedef union packed {
        rv_r_fmt_t r_fmt;
        rv_i_fmt_t i_fmt;
    } rv_instr_u;

    typedef enum logic [3:0] {
        alu_add    = 4'd0,
        alu_sub    = 4'd1,
        alu_sll    = 4'd2,
        alu_slt    = 4'd3,
        alu_sltu   = 4'd4,
        alu_xor    = 4'd5,
        alu_srl    = 4'd6,
        alu_sra    = 4'd7,
        alu_or     = 4'd8,
        alu_and    = 4'd9,
        alu_pass_b = 4'd10  // lui
    } rv_alu_op_e;

    localparam logic [6:0] OPC_OP        = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM    = 7'b0010011;
    localparam logic [6:0] OPC_OP_32     = 7'b0111011;
    localparam logic [6:0] OPC_OP_IMM_32 = 7'b0011011;
    localparam logic [6:0] OPC_LUI       = 7'b0110111;

endpackage

`default_nettype wire

// File: hdl/rv_decode.sv
`default_nettype none

`include "rv_core_cfg.svh"

module rv_decode import rv_core_pkg::*; (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      in_valid,
    input  logic [31:0]               instr,
    input  logic [`RV_XLEN-1:0]       rs1_data,
    input  logic [`RV_XLEN-1:0]       rs2_data,
    input  logic                      ex_valid,
    input  logic [`RV_REG_ADDR_W-1:0] ex_rd,
    input  logic [`RV_XLEN-1:0]       ex_result,
    output logic [`RV_REG_ADDR_W-1:0] rs1_addr,
    output logic [`RV_REG_ADDR_W-1:0] rs2_addr,
    output logic                      id_valid,
    output logic                      id_illegal,
    output rv_alu_op_e                id_op,
    output logic                      id_word,
    output logic [`RV_XLEN-1:0]       id_a,
    output logic [`RV_XLEN-1:0]       id_b,
    output logic [`RV_REG_ADDR_W-1:0] id_rd
);

    rv_instr_u           instr_u;
    rv_alu_op_e          op_dec;
    logic                word_dec;
    logic                legal;
    logic                alt;       // instr bit 30, selects sub and sra
    logic [`RV_XLEN-1:0] i_imm;
    logic [`RV_XLEN-1:0] u_imm;
    logic [`RV_XLEN-1:0] src_a;
    logic [`RV_XLEN-1:0] src_b;
    logic [`RV_XLEN-1:0] operand_b;

    // funct3 map shared by OP and OP-IMM
    function automatic rv_alu_op_e alu_sel(input logic [2:0] f3, input logic sel_alt);
        rv_alu_op_e op;
        case (f3)
            3'b000:  op = sel_alt ? alu_sub : alu_add;
            3'b001:  op = alu_sll;
            3'b010:  op = alu_slt;
            3'b011:  op = alu_sltu;
            3'b100:  op = alu_xor;
            3'b101:  op = sel_alt ? alu_sra : alu_srl;
            3'b110:  op = alu_or;
            default: op = alu_and;
        endcase
        return op;
    endfunction

    assign instr_u  = instr;
    assign rs1_addr = instr_u.r_fmt.rs1;
    assign rs2_addr = instr_u.r_fmt.rs2;
    assign alt      = instr_u.r_fmt.funct7[5];
    assign i_imm    = {{(`RV_XLEN-12){instr_u.i_fmt.imm12[11]}}, instr_u.i_fmt.imm12};
    assign u_imm    = {{(`RV_XLEN-32){instr[31]}}, instr[31:12], 12'b0};

    // execute-stage result wins over the register file
    assign src_a = (ex_valid && (ex_rd != '0) && (ex_rd == rs1_addr)) ? ex_result : rs1_data;
    assign src_b = (ex_valid && (ex_rd != '0) && (ex_rd == rs2_addr)) ? ex_result : rs2_data;

    always_comb begin
        op_dec    = alu_add;
        word_dec  = 1'b0;
        legal     = 1'b1;
        operand_b = src_b;
        case (instr_u.r_fmt.opcode)
            OPC_OP: begin
                op_dec = alu_sel(instr_u.r_fmt.funct3, alt);
            end
            OPC_OP_IMM: begin
                op_dec    = alu_sel(instr_u.i_fmt.funct3, (instr_u.i_fmt.funct3 == 3'b101) && alt);
                operand_b = i_imm;  // shifts take the low 6 bits
            end
            OPC_OP_32: begin
                op_dec   = alt ? alu_sub : alu_add;
                word_dec = 1'b1;
                legal    = (instr_u.r_fmt.funct3 == 3'b000);  // addw, subw only
            end
            OPC_OP_IMM_32: begin
                word_dec  = 1'b1;
                operand_b = i_imm;
                legal     = (instr_u.i_fmt.funct3 == 3'b000);  // addiw only
            end
            OPC_LUI: begin
                op_dec    = alu_pass_b;
                operand_b = u_imm;
            end
            default: begin
                legal = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            id_valid   <= 1'b0;
            id_illegal <= 1'b0;
        end else begin
            id_valid   <= in_valid && legal;
            id_illegal <= in_valid && !legal;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            id_op   <= op_dec;
            id_word <= word_dec;
            id_a    <= src_a;
            id_b    <= operand_b;
            id_rd   <= instr_u.r_fmt.rd;
        end
    end

    a_instr_known : assert property (@(posedge clk) disable iff (!rst_n)
        in_valid |-> !$isunknown(instr));

endmodule

`default_nettype wire

// File: hdl/rv_execute.sv
`default_nettype none

`include "rv_core_cfg.svh"

module rv_execute import rv_core_pkg::*; (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      id_valid,
    input  logic                      id_illegal,
    input  rv_alu_op_e                id_op,
    input  logic                      id_word,
    input  logic [`RV_XLEN-1:0]       id_a,
    input  logic [`RV_XLEN-1:0]       id_b,
    input  logic [`RV_REG_ADDR_W-1:0] id_rd,
    output logic                      ex_valid,
    output logic [`RV_REG_ADDR_W-1:0] ex_rd,
    output logic [`RV_XLEN-1:0]       ex_result,
    output logic                      wb_valid,
    output logic [`RV_REG_ADDR_W-1:0] wb_rd,
    output logic [`RV_XLEN-1:0]       wb_data,
    output logic                      illegal
);

    logic [5:0]          shamt;
    logic [`RV_XLEN-1:0] alu_res;

    assign shamt = id_b[5:0];

    always_comb begin
        case (id_op)
            alu_add:    alu_res = id_a + id_b;
            alu_sub:    alu_res = id_a - id_b;
            alu_sll:    alu_res = id_a << shamt;
            alu_slt:    alu_res = {{(`RV_XLEN-1){1'b0}}, $signed(id_a) < $signed(id_b)};
            alu_sltu:   alu_res = {{(`RV_XLEN-1){1'b0}}, id_a < id_b};
            alu_xor:    alu_res = id_a ^ id_b;
            alu_srl:    alu_res = id_a >> shamt;
            alu_sra:    alu_res = $signed(id_a) >>> shamt;
            alu_or:     alu_res = id_a | id_b;
            alu_and:    alu_res = id_a & id_b;
            alu_pass_b: alu_res = id_b;
            default:    alu_res = '0;
        endcase
    end

    // the low half of add/sub is the 32-bit result, sign-extend it for word ops
    assign ex_result = id_word ? {{(`RV_XLEN-32){alu_res[31]}}, alu_res[31:0]} : alu_res;

    // decode-stage values seen by the forwarding compare
    assign ex_valid = id_valid;
    assign ex_rd    = id_rd;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_valid <= 1'b0;
            illegal  <= 1'b0;
        end else begin
            wb_valid <= id_valid;
            illegal  <= id_illegal;
        end
    end

    always_ff @(posedge clk) begin
        if (id_valid) begin
            wb_rd   <= id_rd;
            wb_data <= ex_result;
        end
    end

    // decode never raises both, so the outputs stay exclusive
    a_wb_illegal_excl : assert property (@(posedge clk) disable iff (!rst_n)
        !(wb_valid && illegal));

endmodule

`default_nettype wire

// File: hdl/rv_reg_file.sv
`default_nettype none

`include "rv_core_cfg.svh"

module rv_reg_file (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      wb_valid,
    input  logic [`RV_REG_ADDR_W-1:0] wb_rd,
    input  logic [`RV_XLEN-1:0]       wb_data,
    input  logic [`RV_REG_ADDR_W-1:0] rs1_addr,
    input  logic [`RV_REG_ADDR_W-1:0] rs2_addr,
    output logic [`RV_XLEN-1:0]       rs1_data,
    output logic [`RV_XLEN-1:0]       rs2_data
);

    logic [`RV_XLEN-1:0] regs [1:`RV_REG_COUNT-1];  // no storage for x0

    // zero for x0, bypass a pending write, else storage
    function automatic logic [`RV_XLEN-1:0] read_port(input logic [`RV_REG_ADDR_W-1:0] addr);
        logic [`RV_XLEN-1:0] rdata;
        if (addr == '0) begin
            rdata = '0;
        end else if (wb_valid && (addr == wb_rd)) begin
            rdata = wb_data;  // write-through
        end else begin
            rdata = regs[addr];
        end
        return rdata;
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < `RV_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_valid && (wb_rd != '0)) begin
            regs[wb_rd] <= wb_data;
        end
    end

    always_comb begin
        rs1_data = read_port(rs1_addr);
        rs2_data = read_port(rs2_addr);
    end

    a_x0_reads_zero : assert property (@(posedge clk) disable iff (!rst_n)
        ((rs1_addr == '0) |-> (rs1_data == '0)) and ((rs2_addr == '0) |-> (rs2_data == '0)));

    // a discarded write to x0 must not show up on the next read of x0
    a_x0_write_dropped : assert property (@(posedge clk) disable iff (!rst_n)
        (wb_valid && (wb_rd == '0) && (wb_data != '0))
        |=> ((rs1_addr != '0) || (rs1_data == '0)) && ((rs2_addr != '0) || (rs2_data == '0)));

endmodule

`default_nettype wire
